// ==== verilog/fetch_pkg.sv ====
package fetch_pkg;

    // datapath and address widths
    localparam int xlen       = 32;
    localparam int addr_width = 32;

    // instruction memory geometry
    localparam int mem_words = 256;
    localparam int mem_aw    = 8;

    localparam logic [6:0] opc_jal = 7'b1101111;

    typedef struct packed {
        logic                  valid;
        logic [addr_width-1:0] addr;
    } imem_req_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] data;
    } imem_resp_t;

    typedef struct packed {
        logic [addr_width-1:0] pc;
        logic [xlen-1:0]       ins;
    } fetch_pkt_t;

    typedef struct packed {
        logic [addr_width-1:0] pc;
        logic [xlen-1:0]       ins;
        logic [6:0]            opcode;
        logic [4:0]            rd;
        logic [4:0]            rs1;
        logic [4:0]            rs2;
        logic [2:0]            funct3;
        logic [xlen-1:0]       imm_i;
        logic                  is_jal;
    } dec_pkt_t;

    // r-format layout, msb first
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } instr_r_t;

    // j-format layout, immediate bits scattered as in the spec
    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } instr_j_t;

    typedef union packed {
        instr_r_t r;
        instr_j_t j;
    } instr_view_u;

endpackage

// ==== verilog/fetch_ctrl.sv ====
`timescale 1ns/1ps

module fetch_ctrl (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             pause,
    input  logic                             redirect,
    input  logic [fetch_pkg::addr_width-1:0] redirect_pc,
    input  logic                             req_ready,
    input  fetch_pkg::imem_resp_t            mem_resp,
    input  logic                             pkt_ready,
    output fetch_pkg::imem_req_t             mem_req,
    output logic                             pkt_valid,
    output fetch_pkg::fetch_pkt_t            pkt
);

    logic                             rst_n_d1;
    logic                             pause_d1;
    logic                             redirect_d1;
    logic                             req_q;
    logic [fetch_pkg::addr_width-1:0] pc;
    logic [fetch_pkg::addr_width-1:0] inflight_pc;
    logic                             start;
    logic                             accept;
    logic                             transfer;
    logic                             capture;
    logic                             drop;
    logic                             slot_free;
    logic                             req_set;
    logic                             redirect_hit;
    logic                             stale_q;

    // first cycle after reset release
    assign start    = !rst_n_d1;
    assign accept   = req_q && req_ready;
    assign transfer = pkt_valid && pkt_ready;
    assign capture  = mem_resp.valid && !pause;
    // a response seen while paused is lost and fetched again
    assign drop     = mem_resp.valid && pause;

    // request accepted along with the redirect already fetches the target
    assign redirect_hit = redirect && accept && (pc == redirect_pc);

    // nothing requested, nothing returning, packet slot empty next cycle
    assign slot_free = !req_q && !mem_resp.valid && (!pkt_valid || transfer);

    assign req_set = !pause && slot_free &&
                     (start || transfer || (pause_d1 && !redirect) || redirect_d1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rst_n_d1    <= 1'b0;
            pause_d1    <= 1'b0;
            redirect_d1 <= 1'b0;
        end else begin
            rst_n_d1    <= 1'b1;
            pause_d1    <= pause;
            redirect_d1 <= redirect;
        end
    end

    // pc always points at the next word to request
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (redirect && !redirect_hit) begin
            pc <= redirect_pc;
        end else if (accept) begin
            pc <= pc + 32'd4;
        end else if (drop && !stale_q) begin
            pc <= inflight_pc;
        end
    end

    // address of the request the memory is answering
    always_ff @(posedge clk) begin
        if (accept) begin
            inflight_pc <= pc;
        end
    end

    // word in flight is off the jump path
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stale_q <= 1'b0;
        end else if (accept) begin
            stale_q <= redirect && !redirect_hit;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_q <= 1'b0;
        end else if (accept) begin
            req_q <= 1'b0;
        end else if (req_set) begin
            req_q <= 1'b1;
        end
    end

    assign mem_req = '{valid: req_q, addr: pc};

    // response data lasts one cycle, sample it now
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pkt_valid <= 1'b0;
        end else if (transfer) begin
            pkt_valid <= 1'b0;
        end else if (capture) begin
            pkt_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            pkt.pc  <= inflight_pc;
            pkt.ins <= mem_resp.data;
        end
    end

    a_pkt_stable : assert property (
        @(posedge clk) disable iff (!rst_n)
        pkt_valid && !pkt_ready |=> pkt_valid && $stable(pkt)
    ) else $error("fetch packet changed before transfer");

    // one request or packet in flight at a time
    a_req_after_pkt : assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(mem_req.valid) |-> !pkt_valid
    ) else $error("request raised while a packet is held");

endmodule

// ==== verilog/instr_mem.sv ====
`timescale 1ns/1ps

module instr_mem (
    input  logic                         clk,
    input  logic                         rst_n,
    input  fetch_pkg::imem_req_t         req,
    input  logic                         load_en,
    input  logic [fetch_pkg::mem_aw-1:0] load_addr,
    input  logic [fetch_pkg::xlen-1:0]   load_data,
    output logic                         req_ready,
    output fetch_pkg::imem_resp_t        resp
);

    logic [fetch_pkg::xlen-1:0]   mem [fetch_pkg::mem_words];
    logic [fetch_pkg::mem_aw-1:0] rd_idx;
    logic                         accept;
    logic                         resp_valid;
    logic [fetch_pkg::xlen-1:0]   resp_data;

    // word index from the byte address
    assign rd_idx = req.addr[fetch_pkg::mem_aw+1:2];

    // loads take the single port
    assign req_ready = !load_en;
    assign accept    = req.valid && req_ready;

    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_addr] <= load_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            resp_data <= mem[rd_idx];
        end
    end

    assign resp = '{valid: resp_valid, data: resp_data};

    // the fetch side keeps a single request outstanding
    a_resp_pulse : assert property (
        @(posedge clk) disable iff (!rst_n)
        resp.valid |=> !resp.valid
    ) else $error("memory response valid held for two cycles");

endmodule

// ==== verilog/predecode.sv ====
`timescale 1ns/1ps

module predecode (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             pkt_valid,
    input  fetch_pkg::fetch_pkt_t            pkt,
    input  logic                             dec_ready,
    output logic                             pkt_ready,
    output logic                             redirect,
    output logic [fetch_pkg::addr_width-1:0] redirect_pc,
    output logic                             dec_valid,
    output fetch_pkg::dec_pkt_t              dec
);

    fetch_pkg::instr_view_u           view;
    fetch_pkg::dec_pkt_t              dec_next;
    logic [fetch_pkg::xlen-1:0]       imm_j;
    logic [fetch_pkg::addr_width-1:0] target;
    logic                             squash_q;
    logic                             take;
    logic                             keep;
    logic                             jal_taken;

    assign view = pkt.ins;

    // output register empty or draining this cycle
    assign pkt_ready = !dec_valid || dec_ready;
    assign take      = pkt_valid && pkt_ready;

    // wrong-path words are accepted but dropped until the target shows up
    assign keep = !squash_q || (pkt.pc == redirect_pc);

    always_comb begin
        dec_next        = '0;
        dec_next.pc     = pkt.pc;
        dec_next.ins    = pkt.ins;
        dec_next.opcode = view.r.opcode;
        dec_next.rd     = view.r.rd;
        dec_next.rs1    = view.r.rs1;
        dec_next.rs2    = view.r.rs2;
        dec_next.funct3 = view.r.funct3;
        // I immediate lives in funct7 and rs2
        dec_next.imm_i  = {{20{view.r.funct7[6]}}, view.r.funct7, view.r.rs2};
        dec_next.is_jal = (view.r.opcode == fetch_pkg::opc_jal);
    end

    assign imm_j = {{11{view.j.imm20}}, view.j.imm20, view.j.imm19_12,
                    view.j.imm11, view.j.imm10_1, 1'b0};
    assign target = pkt.pc + imm_j;

    assign jal_taken = take && keep && dec_next.is_jal;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            redirect <= 1'b0;
            squash_q <= 1'b0;
        end else begin
            redirect <= jal_taken;
            // a kept word either arms a new squash or ends the old one
            if (take && keep) begin
                squash_q <= dec_next.is_jal;
            end
        end
    end

    // also the pc that ends the squash
    always_ff @(posedge clk) begin
        if (jal_taken) begin
            redirect_pc <= target;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec_valid <= 1'b0;
        end else if (take && keep) begin
            dec_valid <= 1'b1;
        end else if (dec_ready) begin
            dec_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take && keep) begin
            dec <= dec_next;
        end
    end

    // fetch cannot deliver two jals back to back
    a_redirect_pulse : assert property (
        @(posedge clk) disable iff (!rst_n)
        redirect |=> !redirect
    ) else $error("redirect high in two consecutive cycles");

endmodule

// ==== verilog/fetch_top.sv ====
`timescale 1ns/1ps

module fetch_top (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         pause,
    input  logic                         mem_load_en,
    input  logic [fetch_pkg::mem_aw-1:0] mem_load_addr,
    input  logic [fetch_pkg::xlen-1:0]   mem_load_data,
    input  logic                         dec_ready,
    output logic                         dec_valid,
    output fetch_pkg::dec_pkt_t          dec
);

    fetch_pkg::imem_req_t             mem_req;
    fetch_pkg::imem_resp_t            mem_resp;
    logic                             req_ready;
    logic                             pkt_valid;
    logic                             pkt_ready;
    fetch_pkg::fetch_pkt_t            pkt;
    logic                             redirect;
    logic [fetch_pkg::addr_width-1:0] redirect_pc;

    fetch_ctrl u_fetch_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .pause       (pause),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .req_ready   (req_ready),
        .mem_resp    (mem_resp),
        .pkt_ready   (pkt_ready),
        .mem_req     (mem_req),
        .pkt_valid   (pkt_valid),
        .pkt         (pkt)
    );

    instr_mem u_instr_mem (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (mem_req),
        .load_en   (mem_load_en),
        .load_addr (mem_load_addr),
        .load_data (mem_load_data),
        .req_ready (req_ready),
        .resp      (mem_resp)
    );

    predecode u_predecode (
        .clk         (clk),
        .rst_n       (rst_n),
        .pkt_valid   (pkt_valid),
        .pkt         (pkt),
        .dec_ready   (dec_ready),
        .pkt_ready   (pkt_ready),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .dec_valid   (dec_valid),
        .dec         (dec)
    );

endmodule

// ==== bench/tb_fetch_tasks.svh ====
// all tasks start and end on a falling edge

task automatic compare_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
        $display("Error: %s got %h expected %h at %0t", name, got, exp, $time);
        error_count++;
    end
endtask

// J immediate by the RISC-V bit layout
function automatic logic [31:0] jal_offset(input logic [31:0] ins);
    return {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
endfunction

function automatic logic [31:0] next_pc(input logic [31:0] pc, input logic [31:0] ins);
    if (ins[6:0] == jal_op) begin
        return pc + jal_offset(ins);
    end
    return pc + 32'd4;
endfunction

function automatic logic [31:0] make_jal(input logic [4:0] rd, input int offset);
    logic [31:0] off;
    off = offset;
    return {off[20], off[10:1], off[11], off[19:12], rd, jal_op};
endfunction

// any word but a jal
function automatic logic [31:0] random_word();
    logic [31:0] w;
    w = $urandom;
    if (w[6:0] == jal_op) begin
        w[0] = ~w[0];
    end
    return w;
endfunction

function automatic logic [31:0] fill_word(input int idx);
    logic [7:0] a;
    a = idx[7:0];
    return {a, ~a, a ^ 8'ha5, 1'b0, 7'h13};
endfunction

task automatic apply_reset(input logic hold_pause);
    @(negedge clk);
    rst_n       = 1'b0;
    pause       = hold_pause;
    dec_ready   = 1'b0;
    mem_load_en = 1'b0;
    repeat (10) @(negedge clk);
    rst_n  = 1'b1;
    exp_pc = '0;
endtask

task automatic write_word(input int idx, input logic [31:0] data);
    mem_load_en   = 1'b1;
    mem_load_addr = idx[7:0];
    mem_load_data = data;
    ref_mem[idx]  = data;
    @(negedge clk);
endtask

task automatic fill_memory();
    for (int i = 0; i < 256; i++) begin
        write_word(i, fill_word(i));
    end
    mem_load_en = 1'b0;
endtask

task automatic load_straight(input int words);
    for (int i = 0; i < words; i++) begin
        write_word(i, random_word());
    end
    mem_load_en = 1'b0;
endtask

// forward jumps at words 3, 6 and 11, backward jump at word 40
task automatic load_jal_program();
    load_straight(48);
    write_word(3, make_jal(5'd1, 24));
    write_word(6, make_jal(5'd0, 4));
    write_word(11, make_jal(5'd5, 100));
    // back to word 4, loops through both forward jumps
    write_word(40, make_jal(5'd1, -144));
    mem_load_en = 1'b0;
endtask

// stop the core and let any response drain
task automatic pause_and_settle();
    pause     = 1'b1;
    dec_ready = 1'b0;
    repeat (6) @(negedge clk);
endtask

task automatic check_transfer();
    logic [31:0] ins;
    ins = ref_mem[exp_pc[9:2]];
    compare_value("dec.pc", dec.pc, exp_pc);
    compare_value("dec.ins", dec.ins, ins);
    compare_value("dec.opcode", 32'(dec.opcode), 32'(ins[6:0]));
    compare_value("dec.rd", 32'(dec.rd), 32'(ins[11:7]));
    compare_value("dec.funct3", 32'(dec.funct3), 32'(ins[14:12]));
    compare_value("dec.rs1", 32'(dec.rs1), 32'(ins[19:15]));
    compare_value("dec.rs2", 32'(dec.rs2), 32'(ins[24:20]));
    compare_value("dec.imm_i", dec.imm_i, {{20{ins[31]}}, ins[31:20]});
    compare_value("dec.is_jal", 32'(dec.is_jal), 32'(ins[6:0] == jal_op));
    exp_pc = next_pc(exp_pc, ins);
endtask

// dec_ready driven here decides the transfer at the next rising edge
task automatic run_transfers(input int count, input bit rand_ready, input bit rand_pause);
    int got;
    int pause_left;
    got        = 0;
    pause_left = 0;
    while (got < count) begin
        if (rand_pause && pause_left > 0) begin
            pause = 1'b1;
            pause_left--;
        end else if (rand_pause && $urandom_range(9) == 0) begin
            pause      = 1'b1;
            pause_left = $urandom_range(12, 1);
        end else begin
            pause = 1'b0;
        end
        dec_ready = rand_ready ? ($urandom_range(1) == 1) : 1'b1;
        if (dec_valid && dec_ready) begin
            check_transfer();
            got++;
        end
        @(negedge clk);
    end
    pause     = 1'b1;
    dec_ready = 1'b0;
endtask

task automatic test_straight_line();
    pause_and_settle();
    load_straight(48);
    apply_reset(1'b0);
    run_transfers(n_straight, 1'b0, 1'b0);
endtask

task automatic test_fields();
    logic [31:0] w;
    pause_and_settle();
    for (int i = 0; i < n_fields; i++) begin
        w = random_word();
        // alternate the I immediate sign
        w[31] = i[0];
        write_word(i, w);
    end
    mem_load_en = 1'b0;
    apply_reset(1'b0);
    run_transfers(n_fields, 1'b0, 1'b0);
endtask

task automatic test_jal_redirect();
    pause_and_settle();
    load_jal_program();
    apply_reset(1'b0);
    run_transfers(n_jal, 1'b0, 1'b0);
    pause_and_settle();
    apply_reset(1'b0);
    run_transfers(n_jal, 1'b1, 1'b0);
endtask

task automatic test_ready_backpressure();
    pause_and_settle();
    load_straight(48);
    apply_reset(1'b0);
    run_transfers(n_ready, 1'b1, 1'b0);
endtask

// pause stretches also land on the jumps
task automatic test_pause();
    pause_and_settle();
    load_jal_program();
    apply_reset(1'b0);
    run_transfers(n_pause, 1'b1, 1'b1);
endtask

task automatic test_load_backpressure();
    int base;
    pause_and_settle();
    apply_reset(1'b1);
    for (int i = 0; i < 45; i++) begin
        write_word(i, random_word());
    end
    // first request waits on req_ready until the load ends
    pause = 1'b0;
    for (int i = 45; i < 48; i++) begin
        write_word(i, random_word());
    end
    mem_load_en = 1'b0;
    run_transfers(n_load_a, 1'b0, 1'b0);

    // rewrite past the words already buffered in the pipe
    pause_and_settle();
    base = int'(exp_pc >> 2) + 4;
    for (int i = 0; i < 24; i++) begin
        write_word(base + i, random_word());
    end
    mem_load_en = 1'b0;
    run_transfers(n_load_b, 1'b1, 1'b0);

    pause_and_settle();
    apply_reset(1'b0);
    run_transfers(n_load_c, 1'b0, 1'b0);
endtask

// ==== bench/tb_fetch.sv ====
`timescale 1ns/1ps

module tb_fetch;

    // transfers checked per test
    localparam int n_straight = 40;
    localparam int n_fields   = 32;
    localparam int n_jal      = 40;
    localparam int n_ready    = 40;
    localparam int n_pause    = 40;
    localparam int n_load_a   = 20;
    localparam int n_load_b   = 24;
    localparam int n_load_c   = 40;

    localparam int total_instr = n_straight + n_fields + 2 * n_jal + n_ready + n_pause +
                                 n_load_a + n_load_b + n_load_c;
    localparam int max_cycles  = 40 * total_instr + 500;

    localparam logic [6:0] jal_op = 7'b1101111;

    logic                clk;
    logic                rst_n;
    logic                pause;
    logic                mem_load_en;
    logic [7:0]          mem_load_addr;
    logic [31:0]         mem_load_data;
    logic                dec_ready;
    logic                dec_valid;
    fetch_pkg::dec_pkt_t dec;

    // bench copy of the instruction memory
    logic [31:0] ref_mem [256];
    // pc of the next transfer the model expects
    logic [31:0] exp_pc;

    int          error_count = 0;
    int          check_count = 0;
    int          cycle_count = 0;

    fetch_top i_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .pause         (pause),
        .mem_load_en   (mem_load_en),
        .mem_load_addr (mem_load_addr),
        .mem_load_data (mem_load_data),
        .dec_ready     (dec_ready),
        .dec_valid     (dec_valid),
        .dec           (dec)
    );

    `include "tb_fetch_tasks.svh"

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= max_cycles) begin
            $display("timeout: the run went past %0d cycles without finishing", max_cycles);
            $display("checks: %0d, errors: %0d", check_count, error_count);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    initial begin
        rst_n         = 1'b0;
        pause         = 1'b1;
        mem_load_en   = 1'b0;
        mem_load_addr = '0;
        mem_load_data = '0;
        dec_ready     = 1'b0;
        exp_pc        = '0;
        void'($urandom(32'hcc90_c028));

        apply_reset(1'b1);
        fill_memory();

        test_straight_line();
        test_fields();
        test_jal_redirect();
        test_ready_backpressure();
        test_pause();
        test_load_backpressure();

        repeat (5) @(negedge clk);
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+bench
verilog/fetch_pkg.sv
verilog/fetch_ctrl.sv
verilog/instr_mem.sv
verilog/predecode.sv
verilog/fetch_top.sv
bench/tb_fetch.sv

// ==== Makefile ====
SIM := obj_dir/Vtb_fetch
LOG := sim.log

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): sources.f $(wildcard verilog/*.sv bench/*.sv bench/*.svh)
	verilator --binary --timing --assert --top-module tb_fetch -Mdir obj_dir -f sources.f

run: $(SIM)
	-./$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then exit 1; fi
	@grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
